// ==== design/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    // Bus and buffer widths
    localparam int data_w = 32;
    localparam int be_w = 4;
    localparam int burst_w = 8;
    localparam int buf_depth_log2 = 9;

    // Transfer states of the engine
    typedef enum logic [3:0] {
        idle,
        init,
        request_bus,
        set_up,
        read,
        read_wait_end,
        write,
        write_end,
        error_end
    } dma_state_t;

    typedef enum logic {
        op_read,
        op_write
    } dma_op_t;

    // Command captured from the host at launch
    typedef struct packed {
        dma_op_t                 op;
        logic [data_w-1:0]       address;
        // One bit wider than the buffer index so a full buffer fits
        logic [buf_depth_log2:0] block_size;
        logic [burst_w-1:0]      burst_size;
        logic [be_w-1:0]         byte_enable;
    } launch_cmd_t;

endpackage

`default_nettype wire

// ==== design/dma_bus_if.sv ====
`default_nettype none

interface dma_bus_if;
    import dma_pkg::*;

    // Driven by the master
    logic [data_w-1:0]  address_data_out;
    logic [be_w-1:0]    byte_enable;
    logic [burst_w-1:0] burst_size;
    logic               read_n_write;
    logic               begin_transaction;
    logic               end_transaction_out;
    logic               data_valid_out;
    logic               busy_out;

    // Driven by the target
    logic [data_w-1:0]  address_data_in;
    logic               end_transaction_in;
    logic               data_valid_in;
    logic               busy_in;
    logic               error;

    modport master (
        output address_data_out, byte_enable, burst_size, read_n_write,
               begin_transaction, end_transaction_out, data_valid_out, busy_out,
        input  address_data_in, end_transaction_in, data_valid_in, busy_in, error
    );

    modport target (
        input  address_data_out, byte_enable, burst_size, read_n_write,
               begin_transaction, end_transaction_out, data_valid_out, busy_out,
        output address_data_in, end_transaction_in, data_valid_in, busy_in, error
    );

endinterface

`default_nettype wire

// ==== design/local_buffer.sv ====
`default_nettype none

module local_buffer #(
    parameter int AW = dma_pkg::buf_depth_log2
) (
    input  logic                       clock,
    input  logic [AW-1:0]              host_addr,
    input  logic [dma_pkg::data_w-1:0] host_wdata,
    input  logic                       host_we,
    output logic [dma_pkg::data_w-1:0] host_rdata,
    input  logic [AW-1:0]              dma_addr,
    input  logic                       dma_we,
    input  logic [dma_pkg::data_w-1:0] dma_wdata,
    output logic [dma_pkg::data_w-1:0] dma_rdata
);
    import dma_pkg::*;

    logic [data_w-1:0] mem [2**AW];

    // DMA wins a same-word collision
    always_ff @(posedge clock) begin
        if (host_we && !(dma_we && dma_addr == host_addr)) begin
            mem[host_addr] <= host_wdata;
        end
        if (dma_we) begin
            mem[dma_addr] <= dma_wdata;
        end
    end

    assign host_rdata = mem[host_addr];
    assign dma_rdata = mem[dma_addr];

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter (
    input  logic clock,
    input  logic n_reset,
    input  logic request_dma,
    input  logic request_ext,
    input  logic bus_end,
    output logic grant_dma,
    output logic grant_ext
);
    logic last_dma;
    logic bus_free;

    assign bus_free = !grant_dma && !grant_ext;

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            grant_dma <= 1'b0;
            grant_ext <= 1'b0;
            last_dma <= 1'b0;
        end else if (!bus_free) begin
            // Owner keeps the bus up to its end strobe
            if (bus_end) begin
                grant_dma <= 1'b0;
                grant_ext <= 1'b0;
            end
        end else if (request_dma && (!request_ext || !last_dma)) begin
            grant_dma <= 1'b1;
            last_dma <= 1'b1;
        end else if (request_ext) begin
            grant_ext <= 1'b1;
            last_dma <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/dma_fsm.sv ====
`default_nettype none

module dma_fsm (
    input  logic                 clock,
    input  logic                 n_reset,
    input  logic                 launch_read,
    input  logic                 launch_write,
    input  dma_pkg::launch_cmd_t cmd,
    input  logic                 grant,
    input  logic                 bus_end_in,
    input  logic                 bus_error,
    input  logic                 bus_busy,
    input  logic                 block_done,
    input  logic                 burst_last,
    output dma_pkg::dma_state_t  state,
    output dma_pkg::launch_cmd_t cmd_q,
    output logic                 request,
    output logic                 busy,
    output logic                 operation_ended
);
    import dma_pkg::*;

    dma_state_t next_state;
    logic       launch;
    logic       active;

    assign launch = launch_read | launch_write;

    always_comb begin
        next_state = state;
        case (state)
            idle:
                next_state = launch ? init : idle;
            init:
                next_state = request_bus;
            // Hold off while an end strobe is still on the bus since the grant is about to drop
            request_bus:
                if (block_done) begin
                    next_state = idle;
                end else if (grant && !bus_end_in) begin
                    next_state = set_up;
                end
            set_up:
                next_state = (cmd_q.op == op_read) ? read : write;
            read:
                if (bus_error) begin
                    next_state = bus_end_in ? idle : read_wait_end;
                end else if (bus_end_in) begin
                    next_state = block_done ? idle : request_bus;
                end
            read_wait_end:
                next_state = bus_end_in ? idle : read_wait_end;
            // Last word of the burst leaves the buffer when the bus is not busy
            write:
                if (bus_error) begin
                    next_state = error_end;
                end else if (burst_last && !bus_busy) begin
                    next_state = write_end;
                end
            write_end:
                if (bus_error) begin
                    next_state = error_end;
                end else if (!bus_busy) begin
                    next_state = block_done ? idle : request_bus;
                end
            error_end:
                next_state = idle;
            default:
                next_state = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (state == idle && launch) begin
            cmd_q <= cmd;
        end
    end

    // Ended flag rises one cycle after the engine is back in idle
    always_ff @(posedge clock) begin
        if (!n_reset) begin
            active <= 1'b0;
            operation_ended <= 1'b0;
        end else begin
            if (state == init) begin
                active <= 1'b1;
            end else if (state == idle) begin
                active <= 1'b0;
            end
            if (launch) begin
                operation_ended <= 1'b0;
            end else if (state == idle && active) begin
                operation_ended <= 1'b1;
            end
        end
    end

    assign busy = (state != idle);
    assign request = (state == request_bus);

endmodule

`default_nettype wire

// ==== design/dma_transfer_counter.sv ====
`default_nettype none

module dma_transfer_counter #(
    parameter int BUF_AW = dma_pkg::buf_depth_log2
) (
    input  logic                       clock,
    input  logic                       n_reset,
    input  dma_pkg::dma_state_t        state,
    input  dma_pkg::launch_cmd_t       cmd_q,
    input  logic                       word_moved,
    output logic [dma_pkg::data_w-1:0] cur_address,
    output logic [BUF_AW-1:0]          buf_index,
    output logic                       block_done,
    output logic                       burst_last
);
    import dma_pkg::*;

    // Wide enough for both the block count and a full burst
    localparam int cnt_w = (BUF_AW > burst_w) ? BUF_AW + 1 : burst_w + 1;

    logic [cnt_w-1:0] remaining;
    logic [cnt_w-1:0] burst_left;
    logic [cnt_w-1:0] burst_len;

    assign burst_len = cnt_w'(cmd_q.burst_size) + cnt_w'(1);

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            cur_address <= '0;
            remaining <= '0;
            buf_index <= '0;
            burst_left <= '0;
        end else if (state == init) begin
            cur_address <= {cmd_q.address[data_w-1:2], 2'b00};
            remaining <= cnt_w'(cmd_q.block_size);
            buf_index <= '0;
        end else if (state == set_up) begin
            // Final burst may be shorter than the programmed length
            burst_left <= (remaining < burst_len) ? remaining : burst_len;
        end else if (word_moved) begin
            cur_address <= cur_address + data_w'(4);
            buf_index <= buf_index + BUF_AW'(1);
            if (remaining != '0) begin
                remaining <= remaining - cnt_w'(1);
            end
            if (burst_left != '0) begin
                burst_left <= burst_left - cnt_w'(1);
            end
        end
    end

    // Last read word is written in the same cycle as the end strobe
    assign block_done = (remaining == '0) || (remaining == cnt_w'(1) && word_moved);
    assign burst_last = (burst_left == cnt_w'(1));

endmodule

`default_nettype wire

// ==== design/dma_bus_datapath.sv ====
`default_nettype none

module dma_bus_datapath (
    input  logic                       clock,
    input  logic                       n_reset,
    input  dma_pkg::dma_state_t        state,
    input  dma_pkg::launch_cmd_t       cmd_q,
    input  logic [dma_pkg::data_w-1:0] cur_address,
    input  logic [dma_pkg::data_w-1:0] buf_rdata,
    output logic                       word_moved,
    output logic                       buf_we,
    output logic [dma_pkg::data_w-1:0] buf_wdata,
    dma_bus_if.master                  bus
);
    import dma_pkg::*;

    logic              write_load;
    logic              write_hold;
    logic              rx_valid;
    logic [data_w-1:0] rx_data;

    // A new write word leaves the buffer only while the target is ready
    assign write_load = (state == write) && !bus.busy_in && !bus.error;
    // Busy from the target freezes the current beat
    assign write_hold = bus.data_valid_out && bus.busy_in && !bus.error;

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            bus.begin_transaction <= 1'b0;
            bus.end_transaction_out <= 1'b0;
            bus.data_valid_out <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            bus.begin_transaction <= (state == set_up);
            bus.end_transaction_out <= (state == write_end && !bus.busy_in && !bus.error)
                                       || (state == error_end);
            bus.data_valid_out <= write_load || write_hold;
            rx_valid <= bus.data_valid_in;
        end
    end

    // Address phase fields and write beats
    always_ff @(posedge clock) begin
        bus.read_n_write <= (state == set_up) && (cmd_q.op == op_read);
        bus.byte_enable <= (state == set_up) ? cmd_q.byte_enable : '0;
        bus.burst_size <= (state == set_up) ? cmd_q.burst_size : '0;
        if (state == set_up) begin
            bus.address_data_out <= {cur_address[data_w-1:2], 2'b00};
        end else if (write_load) begin
            bus.address_data_out <= buf_rdata;
        end else if (!write_hold) begin
            bus.address_data_out <= '0;
        end
        rx_data <= bus.address_data_in;
    end

    // Reads are always accepted at full rate
    assign bus.busy_out = 1'b0;

    assign buf_we = (state == read) && rx_valid;
    assign buf_wdata = rx_data;
    assign word_moved = write_load || buf_we;

endmodule

`default_nettype wire

// ==== design/dma_subsystem.sv ====
`default_nettype none

module dma_subsystem #(
    parameter int BUF_AW = dma_pkg::buf_depth_log2
) (
    input  logic                        clock,
    input  logic                        n_reset,
    // Host launch and command
    input  logic                        launch_read,
    input  logic                        launch_write,
    input  logic [dma_pkg::data_w-1:0]  address,
    input  logic [BUF_AW:0]             block_size,
    input  logic [dma_pkg::burst_w-1:0] burst_size,
    input  logic [dma_pkg::be_w-1:0]    byte_enable,
    output logic                        busy,
    output logic                        operation_ended,
    // Host side of the buffer
    input  logic [BUF_AW-1:0]           host_addr,
    input  logic [dma_pkg::data_w-1:0]  host_wdata,
    input  logic                        host_we,
    output logic [dma_pkg::data_w-1:0]  host_rdata,
    // Shared bus
    input  logic [dma_pkg::data_w-1:0]  address_data_in,
    output logic [dma_pkg::data_w-1:0]  address_data_out,
    output logic [dma_pkg::be_w-1:0]    byte_enable_out,
    output logic [dma_pkg::burst_w-1:0] burst_size_out,
    output logic                        read_n_write_out,
    output logic                        begin_transaction_out,
    input  logic                        end_transaction_in,
    output logic                        end_transaction_out,
    input  logic                        data_valid_in,
    output logic                        data_valid_out,
    input  logic                        busy_in,
    output logic                        busy_out,
    input  logic                        error_in,
    // Second bus master
    input  logic                        request_ext,
    output logic                        grant_ext
);
    import dma_pkg::*;

    launch_cmd_t       cmd;
    launch_cmd_t       cmd_q;
    dma_state_t        state;
    logic              request_dma;
    logic              grant_dma;
    logic              bus_end;
    logic              word_moved;
    logic              block_done;
    logic              burst_last;
    logic              buf_we;
    logic [data_w-1:0] cur_address;
    logic [data_w-1:0] buf_rdata;
    logic [data_w-1:0] buf_wdata;
    logic [BUF_AW-1:0] buf_index;

    dma_bus_if bus ();

    assign cmd = '{
        op:          launch_read ? op_read : op_write,
        address:     address,
        block_size:  (buf_depth_log2 + 1)'(block_size),
        burst_size:  burst_size,
        byte_enable: byte_enable
    };

    // Either side may close a transaction
    assign bus_end = bus.end_transaction_in | bus.end_transaction_out;

    assign bus.address_data_in = address_data_in;
    assign bus.end_transaction_in = end_transaction_in;
    assign bus.data_valid_in = data_valid_in;
    assign bus.busy_in = busy_in;
    assign bus.error = error_in;

    assign address_data_out = bus.address_data_out;
    assign byte_enable_out = bus.byte_enable;
    assign burst_size_out = bus.burst_size;
    assign read_n_write_out = bus.read_n_write;
    assign begin_transaction_out = bus.begin_transaction;
    assign end_transaction_out = bus.end_transaction_out;
    assign data_valid_out = bus.data_valid_out;
    assign busy_out = bus.busy_out;

    dma_fsm u_fsm (
        .clock           (clock),
        .n_reset         (n_reset),
        .launch_read     (launch_read),
        .launch_write    (launch_write),
        .cmd             (cmd),
        .grant           (grant_dma),
        .bus_end_in      (bus_end),
        .bus_error       (bus.error),
        .bus_busy        (bus.busy_in),
        .block_done      (block_done),
        .burst_last      (burst_last),
        .state           (state),
        .cmd_q           (cmd_q),
        .request         (request_dma),
        .busy            (busy),
        .operation_ended (operation_ended)
    );

    dma_transfer_counter #(
        .BUF_AW (BUF_AW)
    ) u_counter (
        .clock       (clock),
        .n_reset     (n_reset),
        .state       (state),
        .cmd_q       (cmd_q),
        .word_moved  (word_moved),
        .cur_address (cur_address),
        .buf_index   (buf_index),
        .block_done  (block_done),
        .burst_last  (burst_last)
    );

    dma_bus_datapath u_datapath (
        .clock       (clock),
        .n_reset     (n_reset),
        .state       (state),
        .cmd_q       (cmd_q),
        .cur_address (cur_address),
        .buf_rdata   (buf_rdata),
        .word_moved  (word_moved),
        .buf_we      (buf_we),
        .buf_wdata   (buf_wdata),
        .bus         (bus)
    );

    local_buffer #(
        .AW (BUF_AW)
    ) u_buffer (
        .clock      (clock),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .host_rdata (host_rdata),
        .dma_addr   (buf_index),
        .dma_we     (buf_we),
        .dma_wdata  (buf_wdata),
        .dma_rdata  (buf_rdata)
    );

    bus_arbiter u_arbiter (
        .clock       (clock),
        .n_reset     (n_reset),
        .request_dma (request_dma),
        .request_ext (request_ext),
        .bus_end     (bus_end),
        .grant_dma   (grant_dma),
        .grant_ext   (grant_ext)
    );

endmodule

`default_nettype wire

// ==== dv/bus_target_model.sv ====
`default_nettype none

module bus_target_model #(
    parameter int DEPTH_LOG2 = 10
) (
    input  logic                  clock,
    input  logic                  n_reset,
    input  logic [31:0]           address_data,
    input  logic [7:0]            burst_size,
    input  logic                  read_n_write,
    input  logic                  begin_transaction,
    input  logic                  master_end,
    input  logic                  master_valid,
    // Configuration from the testbench
    input  logic                  new_block,
    input  logic [7:0]            busy_pattern,
    input  logic                  error_enable,
    input  logic [15:0]           error_beat,
    input  logic                  load_we,
    input  logic [DEPTH_LOG2-1:0] load_addr,
    input  logic [31:0]           load_data,
    output logic [31:0]           read_data,
    output logic                  end_transaction,
    output logic                  data_valid,
    output logic                  busy,
    output logic                  error
);
    typedef enum logic [1:0] {
        t_idle,
        t_read,
        t_write,
        t_end
    } target_mode_t;

    logic [31:0]           mem [2**DEPTH_LOG2];
    target_mode_t          mode;
    logic [DEPTH_LOG2-1:0] word_index;
    logic [8:0]            beats_left;
    logic [15:0]           beat_count;
    logic [2:0]            pattern_pos;
    logic                  error_armed;

    always_ff @(posedge clock) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
        if (!n_reset) begin
            mode <= t_idle;
            end_transaction <= 1'b0;
            data_valid <= 1'b0;
            busy <= 1'b0;
            error <= 1'b0;
            read_data <= '0;
            word_index <= '0;
            beats_left <= '0;
            beat_count <= '0;
            pattern_pos <= '0;
            error_armed <= 1'b0;
        end else begin
            end_transaction <= 1'b0;
            data_valid <= 1'b0;
            busy <= 1'b0;
            error <= 1'b0;
            // Beat numbering for error injection runs over the whole block
            if (new_block) begin
                beat_count <= '0;
                error_armed <= error_enable;
            end
            case (mode)
                t_idle:
                    if (begin_transaction) begin
                        word_index <= address_data[DEPTH_LOG2+1:2];
                        beats_left <= {1'b0, burst_size} + 9'd1;
                        pattern_pos <= '0;
                        mode <= read_n_write ? t_read : t_write;
                    end
                t_read:
                    if (error_armed && beat_count == error_beat) begin
                        error <= 1'b1;
                        error_armed <= 1'b0;
                        mode <= t_end;
                    end else if (beats_left != 9'd0) begin
                        data_valid <= 1'b1;
                        read_data <= mem[word_index];
                        word_index <= word_index + 1'b1;
                        beats_left <= beats_left - 9'd1;
                        beat_count <= beat_count + 16'd1;
                    end else begin
                        end_transaction <= 1'b1;
                        mode <= t_idle;
                    end
                t_write:
                    if (master_end || error) begin
                        mode <= t_idle;
                    end else begin
                        busy <= busy_pattern[pattern_pos];
                        pattern_pos <= pattern_pos + 3'd1;
                        // A beat is taken only while not busy
                        if (master_valid && !busy) begin
                            mem[word_index] <= address_data;
                            word_index <= word_index + 1'b1;
                            beat_count <= beat_count + 16'd1;
                            if (error_armed && beat_count + 16'd1 == error_beat) begin
                                error <= 1'b1;
                                busy <= 1'b0;
                                error_armed <= 1'b0;
                            end
                        end
                    end
                t_end: begin
                    end_transaction <= 1'b1;
                    mode <= t_idle;
                end
                default:
                    mode <= t_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_dma.sv ====
`default_nettype none

module tb_dma;
    import dma_pkg::*;

    localparam int buf_aw = 9;
    localparam int mem_words = 1024;
    localparam int row_count = 8;

    typedef struct packed {
        dma_op_t     op;
        logic [31:0] address;
        logic [9:0]  block_size;
        logic [7:0]  burst_size;
        logic [7:0]  busy_pattern;
        logic        has_error;
        logic [15:0] error_beat;
        logic        ext_request;
    } test_row_t;

    logic        clock = 1'b0;
    logic        n_reset;
    logic        launch_read;
    logic        launch_write;
    logic [31:0] address;
    logic [9:0]  block_size;
    logic [7:0]  burst_size;
    logic [3:0]  byte_enable;
    logic        busy;
    logic        operation_ended;
    logic [8:0]  host_addr;
    logic [31:0] host_wdata;
    logic        host_we;
    logic [31:0] host_rdata;
    logic [31:0] address_data_in;
    logic [31:0] address_data_out;
    logic [3:0]  byte_enable_out;
    logic [7:0]  burst_size_out;
    logic        read_n_write_out;
    logic        begin_transaction_out;
    logic        end_transaction_in;
    logic        end_transaction_out;
    logic        data_valid_in;
    logic        data_valid_out;
    logic        busy_in;
    logic        busy_out;
    logic        error_in;
    logic        request_ext;
    logic        grant_ext;
    logic        target_end;
    logic        ext_end;
    logic [7:0]  busy_pattern_cfg;
    logic        error_enable_cfg;
    logic [15:0] error_beat_cfg;
    logic        load_we;
    logic [9:0]  load_addr;
    logic [31:0] load_data;
    logic        tests_started;

    test_row_t   rows [row_count];
    logic [31:0] mem_before [mem_words];
    logic [31:0] mem_expected [mem_words];
    logic [31:0] buf_expected [2**buf_aw];
    logic [31:0] begin_addrs [$];

    always #50 clock = ~clock;

    // The external master closes its tenure with its own end strobe
    assign end_transaction_in = target_end | ext_end;

    dma_subsystem #(
        .BUF_AW (buf_aw)
    ) u_dut (
        .clock                 (clock),
        .n_reset               (n_reset),
        .launch_read           (launch_read),
        .launch_write          (launch_write),
        .address               (address),
        .block_size            (block_size),
        .burst_size            (burst_size),
        .byte_enable           (byte_enable),
        .busy                  (busy),
        .operation_ended       (operation_ended),
        .host_addr             (host_addr),
        .host_wdata            (host_wdata),
        .host_we               (host_we),
        .host_rdata            (host_rdata),
        .address_data_in       (address_data_in),
        .address_data_out      (address_data_out),
        .byte_enable_out       (byte_enable_out),
        .burst_size_out        (burst_size_out),
        .read_n_write_out      (read_n_write_out),
        .begin_transaction_out (begin_transaction_out),
        .end_transaction_in    (end_transaction_in),
        .end_transaction_out   (end_transaction_out),
        .data_valid_in         (data_valid_in),
        .data_valid_out        (data_valid_out),
        .busy_in               (busy_in),
        .busy_out              (busy_out),
        .error_in              (error_in),
        .request_ext           (request_ext),
        .grant_ext             (grant_ext)
    );

    bus_target_model #(
        .DEPTH_LOG2 (10)
    ) u_target (
        .clock             (clock),
        .n_reset           (n_reset),
        .address_data      (address_data_out),
        .burst_size        (burst_size_out),
        .read_n_write      (read_n_write_out),
        .begin_transaction (begin_transaction_out),
        .master_end        (end_transaction_out),
        .master_valid      (data_valid_out),
        .new_block         (launch_read | launch_write),
        .busy_pattern      (busy_pattern_cfg),
        .error_enable      (error_enable_cfg),
        .error_beat        (error_beat_cfg),
        .load_we           (load_we),
        .load_addr         (load_addr),
        .load_data         (load_data),
        .read_data         (address_data_in),
        .end_transaction   (target_end),
        .data_valid        (data_valid_in),
        .busy              (busy_in),
        .error             (error_in)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // Address phases are recorded and the DMA never back-pressures the bus
    always @(negedge clock) begin
        if (n_reset) begin
            check_value("busy_out", 32'(busy_out), 32'd0);
            if (begin_transaction_out) begin
                check_value("grant_ext", 32'(grant_ext), 32'd0);
                check_value("byte_enable_out", 32'(byte_enable_out), 32'(byte_enable));
                begin_addrs.push_back(address_data_out);
            end
        end
    end

    task automatic fill_target_memory();
        for (int i = 0; i < mem_words; i++) begin
            @(posedge clock);
            load_we <= 1'b1;
            load_addr <= 10'(i);
            load_data <= $urandom;
        end
        @(posedge clock);
        load_we <= 1'b0;
    endtask

    task automatic fill_buffer(input int words);
        logic [31:0] value;
        for (int i = 0; i < words; i++) begin
            value = $urandom;
            buf_expected[i] = value;
            @(posedge clock);
            host_addr <= 9'(i);
            host_wdata <= value;
            host_we <= 1'b1;
        end
        @(posedge clock);
        host_we <= 1'b0;
    endtask

    task automatic launch_transfer(input test_row_t row);
        @(posedge clock);
        launch_read <= (row.op == op_read);
        launch_write <= (row.op == op_write);
        address <= row.address;
        block_size <= row.block_size;
        burst_size <= row.burst_size;
        byte_enable <= 4'($urandom);
        @(posedge clock);
        launch_read <= 1'b0;
        launch_write <= 1'b0;
        @(negedge clock);
        check_value("busy", 32'(busy), 32'd1);
        check_value("operation_ended", 32'(operation_ended), 32'd0);
    endtask

    task automatic run_row(input test_row_t row);
        int          moved;
        int          base;
        int          blen;
        logic [31:0] expected;
        base = int'(row.address[11:2]);
        blen = int'(row.burst_size) + 1;
        moved = row.has_error ? int'(row.error_beat) : int'(row.block_size);
        fill_buffer(int'(row.block_size));
        for (int i = 0; i < mem_words; i++) begin
            mem_before[i] = u_target.mem[i];
        end
        begin_addrs.delete();
        @(posedge clock);
        busy_pattern_cfg <= row.busy_pattern;
        error_enable_cfg <= row.has_error;
        error_beat_cfg <= row.error_beat;
        if (row.ext_request) begin
            @(posedge clock);
            request_ext <= 1'b1;
            do @(negedge clock); while (!grant_ext);
        end
        launch_transfer(row);
        if (row.ext_request) begin
            // DMA has to wait while the other master owns the bus
            repeat (20) @(negedge clock);
            check_value("begin_count_while_ext", 32'(begin_addrs.size()), 32'd0);
            @(posedge clock);
            request_ext <= 1'b0;
            ext_end <= 1'b1;
            @(posedge clock);
            ext_end <= 1'b0;
        end
        do @(negedge clock); while (!operation_ended);
        check_value("busy", 32'(busy), 32'd0);

        if (row.op == op_read) begin
            for (int i = 0; i < int'(row.block_size); i++) begin
                @(posedge clock);
                host_addr <= 9'(i);
                @(negedge clock);
                expected = (i < moved) ? mem_before[base + i] : buf_expected[i];
                check_value($sformatf("host_rdata[%0d]", i), host_rdata, expected);
            end
        end
        for (int i = 0; i < mem_words; i++) begin
            mem_expected[i] = mem_before[i];
        end
        if (row.op == op_write) begin
            for (int i = 0; i < moved; i++) begin
                mem_expected[base + i] = buf_expected[i];
            end
        end
        for (int i = 0; i < mem_words; i++) begin
            check_value($sformatf("target_mem[%0d]", i), u_target.mem[i], mem_expected[i]);
        end

        if (!row.has_error) begin
            check_value("begin_count", 32'(begin_addrs.size()),
                        32'((int'(row.block_size) + blen - 1) / blen));
        end
        for (int j = 0; j < begin_addrs.size(); j++) begin
            check_value("begin_address", begin_addrs[j], row.address + 32'(4 * blen * j));
        end
    endtask

    initial begin
        int limit;
        wait (tests_started);
        limit = 500;
        for (int r = 0; r < row_count; r++) begin
            limit += int'(rows[r].block_size) * 20;
        end
        repeat (limit) @(posedge clock);
        $display("Timeout: the transfers did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h6b2));
        n_reset = 1'b0;
        launch_read = 1'b0;
        launch_write = 1'b0;
        address = '0;
        block_size = '0;
        burst_size = '0;
        byte_enable = '0;
        host_addr = '0;
        host_wdata = '0;
        host_we = 1'b0;
        request_ext = 1'b0;
        ext_end = 1'b0;
        busy_pattern_cfg = '0;
        error_enable_cfg = 1'b0;
        error_beat_cfg = '0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        tests_started = 1'b0;

        // op, address, block, burst, busy pattern, error, error beat, external request
        rows[0] = '{op_read,  32'h100, 10'd16, 8'd3, 8'h00, 1'b0, 16'd0, 1'b0};
        rows[1] = '{op_write, 32'h200, 10'd16, 8'd3, 8'h00, 1'b0, 16'd0, 1'b0};
        rows[2] = '{op_read,  32'h040, 10'd10, 8'd3, 8'h00, 1'b0, 16'd0, 1'b0};
        rows[3] = '{op_write, 32'h300, 10'd13, 8'd4, 8'h64, 1'b0, 16'd0, 1'b0};
        rows[4] = '{op_write, 32'h400, 10'd20, 8'd7, 8'hb2, 1'b0, 16'd0, 1'b0};
        rows[5] = '{op_read,  32'h500, 10'd16, 8'd3, 8'h00, 1'b1, 16'd6, 1'b0};
        rows[6] = '{op_write, 32'h600, 10'd16, 8'd3, 8'h40, 1'b1, 16'd6, 1'b0};
        rows[7] = '{op_read,  32'h700, 10'd8,  8'd1, 8'h00, 1'b0, 16'd0, 1'b1};

        repeat (5) @(posedge clock);
        n_reset <= 1'b1;
        fill_target_memory();
        tests_started = 1'b1;
        for (int r = 0; r < row_count; r++) begin
            run_row(rows[r]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/dma_pkg.sv
design/dma_bus_if.sv
design/local_buffer.sv
design/bus_arbiter.sv
design/dma_fsm.sv
design/dma_transfer_counter.sv
design/dma_bus_datapath.sv
design/dma_subsystem.sv
dv/bus_target_model.sv
dv/tb_dma.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing -f all.f --top-module tb_dma -Mdir obj_dir
	./obj_dir/Vtb_dma

lint:
	verilator --lint-only --timing -f all.f --top-module tb_dma

clean:
	rm -rf obj_dir
